//--- vlog.f
rtl/relu_cfg_pkg.sv
rtl/relu_mem_pkg.sv
rtl/relu_bank_sram.sv
rtl/relu_cpu_port.sv
rtl/relu_engine.sv
rtl/relu_matrix_top.sv
verif/relu_matrix_properties.sv
verif/relu_matrix_tb.sv

//--- Bender.yml
package:
  name: relu_matrix

sources:
  # Packages first, then leaf modules, then the top level
  - rtl/relu_cfg_pkg.sv
  - rtl/relu_mem_pkg.sv
  - rtl/relu_bank_sram.sv
  - rtl/relu_cpu_port.sv
  - rtl/relu_engine.sv
  - rtl/relu_matrix_top.sv

  - target: simulation
    files:
      - verif/relu_matrix_properties.sv
      - verif/relu_matrix_tb.sv

//--- verif/relu_matrix_tb.sv
`timescale 1ns/1ps
`default_nettype none

module relu_matrix_tb
  import relu_cfg_pkg::*;
  import relu_mem_pkg::*;
;

  localparam int NROWS = 4;
  localparam int NCOLS = 5;
  localparam int ELEMS = NROWS * NCOLS;

  // Four engine runs, three full readbacks plus short read bursts, writes, margin
  localparam int MAX_CYCLES = 4 * ELEMS * 8 + 3 * ELEMS * 5 + 12 * 5 + 2 * (ELEMS + 5) + 200;

  // One outstanding read as seen by the compare process
  typedef struct packed {
    int unsigned cyc;
    logic        chk;
    int unsigned row;
    int unsigned col;
    elem_u       val;
  } rd_exp_t;

  logic        clk;
  logic        rst_n;
  logic        start;
  logic        cpu_x_we;
  logic [31:0] cpu_x_row;
  logic [31:0] cpu_x_col;
  elem_u       cpu_x_wdata;
  logic        cpu_y_re;
  logic [31:0] cpu_y_row;
  logic [31:0] cpu_y_col;
  elem_u       cpu_y_rdata;
  logic        cpu_y_rvalid;
  logic        busy;
  logic        done;

  integer      seed;
  int unsigned cycle_cnt;
  int unsigned run_cyc;
  int unsigned done_cyc;
  int          err_cnt;
  int          err_at_start;
  int          test_pass;
  int          test_fail;
  elem_u       shadow_x [ELEMS];
  rd_exp_t     exp_q [$];

  relu_matrix_top #(.NRows(NROWS), .NCols(NCOLS), .NB(2)) dut_i (.*);

  bind relu_matrix_top relu_matrix_properties props_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .busy         (busy),
    .done         (done),
    .cpu_y_re     (cpu_y_re),
    .cpu_y_rvalid (cpu_y_rvalid),
    .x_req        (x_req),
    .y_req        (y_req)
  );

  // ----------------------------------------
  // Clock, cycle count, watchdog
  // ----------------------------------------

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  initial begin : watchdog
    wait (cycle_cnt >= MAX_CYCLES);
    $display("Simulation timed out waiting for done or read data");
    test_fail++;
    $display("Tests passed: %0d, failed: %0d", test_pass, test_fail);
    $display("Verification failed");
    $finish;
  end

  // ----------------------------------------
  // Model and checks
  // ----------------------------------------

  // ReLU on a signed word: negative goes to zero
  function automatic elem_u relu_ref(input elem_u x);
    elem_u r;
    r = x;
    if (x.sm.sign) begin
      r.raw = '0;
    end
    return r;
  endfunction

  task automatic check_elem(input int unsigned r, input int unsigned c,
                            input elem_u got, input elem_u exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: Y[%0d][%0d] read %h, expected %h", $time, r, c, got.raw, exp.raw);
      err_cnt++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s is %b, expected %b", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  // Read data is stable at the falling edge
  always @(negedge clk) begin : compare_proc
    rd_exp_t e;
    if (rst_n) begin
      if (exp_q.size() > 0 && exp_q[0].cyc == cycle_cnt) begin
        e = exp_q.pop_front();
        if (cpu_y_rvalid !== 1'b1) begin
          $display("At %0t cpu_y_rvalid did not rise three edges after the read of Y[%0d][%0d]",
                   $time, e.row, e.col);
          err_cnt++;
        end else if (e.chk) begin
          check_elem(e.row, e.col, cpu_y_rdata, e.val);
        end
      end else if (cpu_y_rvalid === 1'b1) begin
        $display("At %0t cpu_y_rvalid went high with no read due", $time);
        err_cnt++;
      end
    end
  end

  // ----------------------------------------
  // Stimulus tasks, all entered 1 ns after a rising edge
  // ----------------------------------------

  task automatic next_cycle;
    @(posedge clk);
    #1;
  endtask

  task automatic write_x(input int r, input int c, input elem_u w);
    cpu_x_we    = 1'b1;
    cpu_x_row   = r;
    cpu_x_col   = c;
    cpu_x_wdata = w;
    shadow_x[r * NCOLS + c] = w;
    next_cycle();
    cpu_x_we = 1'b0;
  endtask

  // Strobe, then two idle cycles so the next strobe lands after the window
  task automatic read_y(input int r, input int c, input logic chk);
    rd_exp_t e;
    cpu_y_re  = 1'b1;
    cpu_y_row = r;
    cpu_y_col = c;
    next_cycle();
    cpu_y_re = 1'b0;
    e.cyc    = cycle_cnt + 2;
    e.chk    = chk;
    e.row    = r;
    e.col    = c;
    e.val    = relu_ref(shadow_x[r * NCOLS + c]);
    exp_q.push_back(e);
    repeat (2) next_cycle();
  endtask

  task automatic drain_reads;
    while (exp_q.size() != 0) begin
      next_cycle();
    end
  endtask

  task automatic readback_all;
    for (int i = 0; i < ELEMS; i++) begin
      read_y(i / NCOLS, i % NCOLS, 1'b1);
    end
    drain_reads();
  endtask

  // busy must rise at the edge that samples start
  task automatic start_run;
    check_flag("busy before start", busy, 1'b0);
    start = 1'b1;
    next_cycle();
    start = 1'b0;
    run_cyc = cycle_cnt;
    check_flag("busy after start", busy, 1'b1);
  endtask

  // busy holds until done, done lasts one cycle
  task automatic wait_done;
    while (done !== 1'b1) begin
      check_flag("busy during run", busy, 1'b1);
      next_cycle();
    end
    done_cyc = cycle_cnt;
    check_flag("busy at done", busy, 1'b0);
    next_cycle();
    check_flag("done after pulse", done, 1'b0);
  endtask

  task automatic end_test(input int num, input string name);
    if (err_cnt == err_at_start) begin
      test_pass++;
      $display("Test %0d %s: PASS", num, name);
    end else begin
      test_fail++;
      $display("Test %0d %s: FAIL (%0d errors)", num, name, err_cnt - err_at_start);
    end
    err_at_start = err_cnt;
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------

  initial begin : main
    elem_u w;
    int    idx;
    clk = 1'b0;
    rst_n = 1'b0;
    start = 1'b0;
    cpu_x_we = 1'b0;
    cpu_x_row = '0;
    cpu_x_col = '0;
    cpu_x_wdata = '0;
    cpu_y_re = 1'b0;
    cpu_y_row = '0;
    cpu_y_col = '0;
    seed = 32'haaae;
    cycle_cnt = 0;
    err_cnt = 0;
    err_at_start = 0;
    test_pass = 0;
    test_fail = 0;
    repeat (5) next_cycle();
    rst_n = 1'b1;

    // Idle outputs right after reset
    check_flag("busy", busy, 1'b0);
    check_flag("done", done, 1'b0);
    check_flag("cpu_y_rvalid", cpu_y_rvalid, 1'b0);
    next_cycle();
    check_flag("busy", busy, 1'b0);
    end_test(1, "reset state");

    // Random data, sign forced to alternate
    for (int i = 0; i < ELEMS; i++) begin
      w.raw = $random(seed);
      w.sm.sign = i[0];
      write_x(i / NCOLS, i % NCOLS, w);
    end
    start_run();
    wait_done();
    readback_all();
    end_test(2, "random matrix");

    // Second start inside the run must be ignored
    start_run();
    repeat (2) next_cycle();
    start = 1'b1;
    next_cycle();
    start = 1'b0;
    check_flag("busy after extra start", busy, 1'b1);
    wait_done();
    // No CPU traffic here, so three edges per element and no restart
    check_flag("run of three edges per element", (done_cyc - run_cyc) == 3 * ELEMS, 1'b1);
    readback_all();
    end_test(3, "busy and done control");

    // Edge values at a few positions
    w.raw = 32'h8000_0000;
    write_x(0, 0, w);
    w.raw = 32'hffff_ffff;
    write_x(1, 2, w);
    w.raw = 32'h0000_0000;
    write_x(2, 4, w);
    w.raw = 32'h0000_0001;
    write_x(3, 1, w);
    w.raw = 32'h7fff_ffff;
    write_x(3, 4, w);
    start_run();
    wait_done();
    readback_all();
    end_test(4, "edge values");

    // Read latency while idle with data, then under engine contention
    for (int i = 0; i < 6; i++) begin
      idx = {$random(seed)} % ELEMS;
      read_y(idx / NCOLS, idx % NCOLS, 1'b1);
    end
    start_run();
    for (int i = 0; i < 6; i++) begin
      idx = {$random(seed)} % ELEMS;
      read_y(idx / NCOLS, idx % NCOLS, 1'b0);
    end
    wait_done();
    drain_reads();
    end_test(5, "read latency");

    repeat (3) next_cycle();
    $display("Tests passed: %0d, failed: %0d", test_pass, test_fail);
    if (test_fail == 0 && err_cnt == 0 && dut_i.props_i.fail_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/relu_matrix_properties.sv
`timescale 1ns/1ps
`default_nettype none

module relu_matrix_properties
  import relu_cfg_pkg::*;
  import relu_mem_pkg::*;
(
  input logic                       clk,
  input logic                       rst_n,
  input logic                       busy,
  input logic                       done,
  input logic                       cpu_y_re,
  input logic                       cpu_y_rvalid,
  input mem_req_t [NUM_STREAMS-1:0] x_req,
  input mem_req_t [NUM_STREAMS-1:0] y_req
);

  // Count of failed assertions
  int unsigned fail_cnt = 0;

  // ----------------------------------------
  // Engine status
  // ----------------------------------------

  // Single-cycle pulse
  done_pulse_a: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
    else begin
      $error("done held for more than one cycle");
      fail_cnt++;
    end

  // done only ends a run
  done_after_busy_a: assert property (@(posedge clk) disable iff (!rst_n) done |-> $past(busy))
    else begin
      $error("done without busy in the cycle before");
      fail_cnt++;
    end

  // ----------------------------------------
  // CPU read latency
  // ----------------------------------------

  // Pending CPU read on Y marks a strobe taken one edge earlier
  rd_latency_a: assert property (@(posedge clk) disable iff (!rst_n)
    y_req[STREAM_CPU].valid |-> $past(cpu_y_re) ##2 cpu_y_rvalid)
    else begin
      $error("cpu_y_rvalid not three edges after the accepted cpu_y_re");
      fail_cnt++;
    end

  // Quiet while in reset
  reset_quiet_a: assert property (@(posedge clk) !rst_n |->
    !(busy || x_req[0].valid || x_req[1].valid || y_req[0].valid || y_req[1].valid))
    else begin
      $error("request valid or busy seen during reset");
      fail_cnt++;
    end

endmodule

`default_nettype wire

//--- rtl/relu_matrix_top.sv
`timescale 1ns/1ps
`default_nettype none

module relu_matrix_top
  import relu_cfg_pkg::*;
  import relu_mem_pkg::*;
#(
  parameter int NRows = 4,
  parameter int NCols = 5,
  parameter int NB    = 2
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        start,
  input  logic        cpu_x_we,
  input  logic [31:0] cpu_x_row,
  input  logic [31:0] cpu_x_col,
  input  elem_u       cpu_x_wdata,
  input  logic        cpu_y_re,
  input  logic [31:0] cpu_y_row,
  input  logic [31:0] cpu_y_col,
  output elem_u       cpu_y_rdata,
  output logic        cpu_y_rvalid,
  output logic        busy,
  output logic        done
);

  // ----------------------------------------
  // Memory streams
  // ----------------------------------------

  // Index 0 from the CPU port, index 1 from the engine
  mem_req_t [NUM_STREAMS-1:0] x_req;
  mem_req_t [NUM_STREAMS-1:0] y_req;
  logic     [NUM_STREAMS-1:0] x_ready;
  logic     [NUM_STREAMS-1:0] y_ready;
  mem_rsp_t [NUM_STREAMS-1:0] x_rsp;
  mem_rsp_t [NUM_STREAMS-1:0] y_rsp;

  relu_bank_sram #(.NB(NB)) x_mem_i (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (x_req),
    .ready (x_ready),
    .rsp   (x_rsp)
  );

  relu_bank_sram #(.NB(NB)) y_mem_i (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (y_req),
    .ready (y_ready),
    .rsp   (y_rsp)
  );

  // ----------------------------------------
  // Requesters
  // ----------------------------------------

  // CPU writes X and reads Y
  relu_cpu_port #(.NRows(NRows), .NCols(NCols)) cpu_port_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .cpu_x_we     (cpu_x_we),
    .cpu_y_re     (cpu_y_re),
    .cpu_x_row    (cpu_x_row),
    .cpu_x_col    (cpu_x_col),
    .cpu_y_row    (cpu_y_row),
    .cpu_y_col    (cpu_y_col),
    .cpu_x_wdata  (cpu_x_wdata),
    .x_req        (x_req[STREAM_CPU]),
    .y_req        (y_req[STREAM_CPU]),
    .y_ready      (y_ready[STREAM_CPU]),
    .y_rsp        (y_rsp[STREAM_CPU]),
    .cpu_y_rdata  (cpu_y_rdata),
    .cpu_y_rvalid (cpu_y_rvalid)
  );

  // Engine reads X and writes Y, so its Y response goes nowhere
  relu_engine #(.NRows(NRows), .NCols(NCols)) engine_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (start),
    .busy    (busy),
    .done    (done),
    .x_req   (x_req[STREAM_ENG]),
    .y_req   (y_req[STREAM_ENG]),
    .x_ready (x_ready[STREAM_ENG]),
    .y_ready (y_ready[STREAM_ENG]),
    .x_rsp   (x_rsp[STREAM_ENG])
  );

endmodule

`default_nettype wire

//--- rtl/relu_engine.sv
`timescale 1ns/1ps
`default_nettype none

module relu_engine
  import relu_cfg_pkg::*;
  import relu_mem_pkg::*;
#(
  parameter int NRows = 4,
  parameter int NCols = 5
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     start,
  output logic     busy,
  output logic     done,
  output mem_req_t x_req,
  output mem_req_t y_req,
  input  logic     x_ready,
  input  logic     y_ready,
  input  mem_rsp_t x_rsp
);

  // Index of the final element in a run
  localparam addr_t LAST = addr_t'(NRows * NCols - 1);

  typedef enum logic [1:0] {
    IDLE,
    READ,
    WAIT,
    WRITE
  } state_e;

  state_e state_q;
  addr_t  idx_q;
  addr_t  addr_q;
  elem_u  word_q;
  elem_u  relu_word;

  // ----------------------------------------
  // ReLU
  // ----------------------------------------

  // Negative words clamp to zero, everything else passes
  always_comb begin
    relu_word.raw = word_q.sm.sign ? '0 : word_q.raw;
  end

  // ----------------------------------------
  // Requests
  // ----------------------------------------

  // X read in READ, Y write in WRITE, both held while ready is low
  always_comb begin
    x_req       = '0;
    x_req.valid = (state_q == READ);
    x_req.addr  = idx_q;

    y_req       = '0;
    y_req.valid = (state_q == WRITE);
    y_req.we    = 1'b1;
    y_req.addr  = addr_q;
    y_req.wdata = relu_word;
  end

  // ----------------------------------------
  // FSM
  // ----------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      idx_q   <= '0;
      busy    <= 1'b0;
      done    <= 1'b0;
    end else begin
      // done is a single-cycle pulse
      done <= 1'b0;
      case (state_q)
        IDLE: begin
          // start while busy never reaches here
          if (start) begin
            idx_q   <= '0;
            busy    <= 1'b1;
            state_q <= READ;
          end
        end
        READ: begin
          if (x_ready) begin
            state_q <= WAIT;
          end
        end
        WAIT: begin
          if (x_rsp.valid) begin
            state_q <= WRITE;
          end
        end
        WRITE: begin
          if (y_ready) begin
            if (idx_q == LAST) begin
              busy    <= 1'b0;
              done    <= 1'b1;
              state_q <= IDLE;
            end else begin
              idx_q   <= idx_q + 1'b1;
              state_q <= READ;
            end
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Address and word of the element in flight
  always_ff @(posedge clk) begin
    if (state_q == READ && x_ready) begin
      addr_q <= idx_q;
    end
    if (state_q == WAIT && x_rsp.valid) begin
      word_q <= x_rsp.rdata;
    end
  end

endmodule

`default_nettype wire

//--- rtl/relu_cpu_port.sv
`timescale 1ns/1ps
`default_nettype none

module relu_cpu_port
  import relu_cfg_pkg::*;
  import relu_mem_pkg::*;
#(
  parameter int NRows = 4,
  parameter int NCols = 5
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        cpu_x_we,
  input  logic        cpu_y_re,
  input  logic [31:0] cpu_x_row,
  input  logic [31:0] cpu_x_col,
  input  logic [31:0] cpu_y_row,
  input  logic [31:0] cpu_y_col,
  input  elem_u       cpu_x_wdata,
  output mem_req_t    x_req,
  output mem_req_t    y_req,
  input  logic        y_ready,
  input  mem_rsp_t    y_rsp,
  output elem_u       cpu_y_rdata,
  output logic        cpu_y_rvalid
);

  // Matrix must fit the linear address space
  if (NRows * NCols > (1 << ADDR_W)) begin : g_size_check
    $error("relu_cpu_port: NRows * NCols exceeds the address space");
  end

  // ----------------------------------------
  // Address decode
  // ----------------------------------------

  // Row major, wide product, then cut to the address width
  function automatic addr_t lin_addr(input logic [31:0] row, input logic [31:0] col);
    logic [63:0] full;
    full = (64'(row) * 64'(NCols)) + 64'(col);
    return full[ADDR_W-1:0];
  endfunction

  // X write goes straight out on the CPU stream, never stalled
  always_comb begin
    x_req.valid = cpu_x_we;
    x_req.we    = 1'b1;
    x_req.addr  = lin_addr(cpu_x_row, cpu_x_col);
    x_req.wdata = cpu_x_wdata;
  end

  // ----------------------------------------
  // Pending Y read
  // ----------------------------------------

  logic  pend_q;
  addr_t pend_addr_q;
  logic  take_re;

  // New strobe only when nothing is pending or returning
  assign take_re = cpu_y_re && !pend_q && !y_rsp.valid;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pend_q <= 1'b0;
    end else if (take_re) begin
      pend_q <= 1'b1;
    end else if (pend_q && y_ready) begin
      pend_q <= 1'b0;
    end
  end

  // Address held with the pending flag
  always_ff @(posedge clk) begin
    if (take_re) begin
      pend_addr_q <= lin_addr(cpu_y_row, cpu_y_col);
    end
  end

  // Read request, held until the memory takes it
  always_comb begin
    y_req.valid = pend_q;
    y_req.we    = 1'b0;
    y_req.addr  = pend_addr_q;
    y_req.wdata = '0;
  end

  // ----------------------------------------
  // Result register
  // ----------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cpu_y_rvalid <= 1'b0;
    end else begin
      cpu_y_rvalid <= y_rsp.valid;
    end
  end

  // Data only moves with a response
  always_ff @(posedge clk) begin
    if (y_rsp.valid) begin
      cpu_y_rdata <= y_rsp.rdata;
    end
  end

endmodule

`default_nettype wire

//--- rtl/relu_bank_sram.sv
`timescale 1ns/1ps
`default_nettype none

module relu_bank_sram
  import relu_cfg_pkg::*;
  import relu_mem_pkg::*;
#(
  parameter int NB = 2
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  mem_req_t [NUM_STREAMS-1:0]       req,
  output logic     [NUM_STREAMS-1:0]       ready,
  output mem_rsp_t [NUM_STREAMS-1:0]       rsp
);

  // ----------------------------------------
  // Geometry
  // ----------------------------------------

  // Bank index bits, at least one so the index vector stays legal
  localparam int BANK_W = (NB > 1) ? $clog2(NB) : 1;

  // Row bits within a bank, the address minus its bank bits
  localparam int ROW_W = ADDR_W - $clog2(NB);

  // Words per bank, the whole address space split evenly
  localparam int BANK_ROWS = 1 << ROW_W;

  // Bank select uses the low address bits, which needs NB a power of two
  if ((NB < 1) || ((NB & (NB - 1)) != 0)) begin : g_nb_check
    $error("relu_bank_sram: NB must be a power of two");
  end

  // ----------------------------------------
  // Storage and decode
  // ----------------------------------------

  // One array per bank
  elem_u bank_q [NB][BANK_ROWS];

  logic [BANK_W-1:0]      bank_idx [NUM_STREAMS];
  logic [ROW_W-1:0]       row_idx  [NUM_STREAMS];
  logic [NUM_STREAMS-1:0] wr_acc;
  logic [NUM_STREAMS-1:0] rd_acc;
  logic                   same_bank;

  // Bank is address modulo NB, row is the remaining upper bits
  always_comb begin
    for (int s = 0; s < NUM_STREAMS; s++) begin
      bank_idx[s] = BANK_W'(req[s].addr % NB);
      row_idx[s]  = ROW_W'(req[s].addr / NB);
    end
  end

  // ----------------------------------------
  // Arbitration
  // ----------------------------------------

  // Engine loses only to a live CPU request in the same bank
  assign same_bank = req[STREAM_CPU].valid &&
                     (bank_idx[STREAM_CPU] == bank_idx[STREAM_ENG]);

  always_comb begin
    ready             = '1;
    ready[STREAM_ENG] = !same_bank;
  end

  // Accepted writes and reads per stream
  always_comb begin
    for (int s = 0; s < NUM_STREAMS; s++) begin
      wr_acc[s] = req[s].valid && ready[s] && req[s].we;
      rd_acc[s] = req[s].valid && ready[s] && !req[s].we;
    end
  end

  // ----------------------------------------
  // Array access
  // ----------------------------------------

  // Write lands at the accepting edge
  // Two writes never share a bank, arbitration blocks that
  always_ff @(posedge clk) begin
    for (int s = 0; s < NUM_STREAMS; s++) begin
      if (wr_acc[s]) begin
        bank_q[bank_idx[s]][row_idx[s]] <= req[s].wdata;
      end
    end
  end

  // Read data captured at the accepting edge
  elem_u rdata_q [NUM_STREAMS];

  always_ff @(posedge clk) begin
    for (int s = 0; s < NUM_STREAMS; s++) begin
      if (rd_acc[s]) begin
        rdata_q[s] <= bank_q[bank_idx[s]][row_idx[s]];
      end
    end
  end

  // Response valid, one cycle per accepted read
  logic [NUM_STREAMS-1:0] rvalid_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rvalid_q <= '0;
    end else begin
      rvalid_q <= rd_acc;
    end
  end

  always_comb begin
    for (int s = 0; s < NUM_STREAMS; s++) begin
      rsp[s].valid = rvalid_q[s];
      rsp[s].rdata = rdata_q[s];
    end
  end

endmodule

`default_nettype wire

//--- rtl/relu_mem_pkg.sv
`default_nettype none

package relu_mem_pkg;

  import relu_cfg_pkg::*;

  // ----------------------------------------
  // Stream indices
  // ----------------------------------------

  // Two requesters per memory
  localparam int NUM_STREAMS = 2;

  // CPU owns stream 0 and wins every bank conflict
  localparam int STREAM_CPU = 0;

  // Engine owns stream 1 and waits on conflict
  localparam int STREAM_ENG = 1;

  // ----------------------------------------
  // Request and response
  // ----------------------------------------

  // One stream's request, 50 bits
  // Held unchanged by the requester until valid and ready meet
  typedef struct packed {
    logic  valid;
    logic  we;
    addr_t addr;
    elem_u wdata;
  } mem_req_t;

  // One stream's read response, 33 bits
  // valid is high for the cycle after the accepting edge
  typedef struct packed {
    logic  valid;
    elem_u rdata;
  } mem_rsp_t;

endpackage

`default_nettype wire

//--- rtl/relu_cfg_pkg.sv
`default_nettype none

package relu_cfg_pkg;

  // ----------------------------------------
  // Widths
  // ----------------------------------------

  // Matrix element width
  // Fixed, the packed request and response structs depend on it
  localparam int DATA_W = 32;

  // Linear element address width
  localparam int ADDR_W = 16;

  // Linear element address, row * NCols + col
  typedef logic [ADDR_W-1:0] addr_t;

  // ----------------------------------------
  // Element word
  // ----------------------------------------

  // Two's complement word split at the sign bit
  // mag keeps the low bits as stored, not an absolute value
  typedef struct packed {
    logic              sign;
    logic [DATA_W-2:0] mag;
  } elem_sm_t;

  // One matrix element
  // raw for storage and transport, sm where only the sign matters
  typedef union packed {
    logic [DATA_W-1:0] raw;
    elem_sm_t          sm;
  } elem_u;

endpackage

`default_nettype wire
